//--- Makefile
# Verilator build and run of the F100-L core testbench

VERILATOR  ?= verilator
TOP        ?= f100_tb
LOG        ?= sim.log
SEED_FLAGS ?= +verilator+seed+15873
BUILD_DIR  ?= obj_dir
FILELIST   ?= filelist.f
VFLAGS     ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SEED_FLAGS) > $(LOG) 2>&1; \
	status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
+incdir+hdl
hdl/f100_pkg.sv
hdl/f100_alu.sv
hdl/f100_control.sv
hdl/f100_memory.sv
hdl/f100_top.sv
verification/f100_asserts.sv
verification/f100_checker.sv
verification/f100_tb.sv

//--- hdl/f100_alu.sv
//********************************************************************
// F100-L ALU
// Memory-reference operation result, destination and condition bits
//********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_alu
(
  input  f100_pkg::alu_op_e           op,
  input  logic [`F100_WORD_BITS-1:0]  accum,
  input  logic [`F100_WORD_BITS-1:0]  operand,
  input  f100_pkg::flags_t            flags_in,
  output logic [`F100_WORD_BITS:0]    result,
  output f100_pkg::dest_e             dest,
  output f100_pkg::flags_t            flags_out
);

  import f100_pkg::*;

  logic [`F100_WORD_BITS:0] sum;
  logic [`F100_WORD_BITS:0] diff;
  logic                     is_add;
  logic                     is_sub;

  // Carry and borrow land in the top bit
  assign sum  = {1'b0, operand} + {1'b0, accum};
  assign diff = {1'b0, operand} - {1'b0, accum};

  always_comb
  begin
    result = '0;
    dest   = DEST_NONE;
    is_add = 1'b0;
    is_sub = 1'b0;
    case (op)
      OP_ADD: begin result = sum;  dest = DEST_A;   is_add = 1'b1; end
      OP_ADS: begin result = sum;  dest = DEST_MEM; is_add = 1'b1; end
      OP_SUB: begin result = diff; dest = DEST_A;   is_sub = 1'b1; end
      OP_SBS: begin result = diff; dest = DEST_MEM; is_sub = 1'b1; end
      // Compare only sets the flags, V is left alone
      OP_CMP: result = diff;
      OP_AND: begin result = {1'b0, accum & operand}; dest = DEST_A; end
      OP_NEQ: begin result = {1'b0, accum ^ operand}; dest = DEST_A; end
      OP_LDA: begin result = {1'b0, operand}; dest = DEST_A; end
      OP_JMP: begin result = {1'b0, operand}; dest = DEST_PC; end
      OP_STO: begin result = {1'b0, accum}; dest = DEST_MEM; end
      default: result = '0;
    endcase
  end

  always_comb
  begin
    flags_out.c = result[`F100_WORD_BITS];
    flags_out.s = result[`F100_WORD_BITS-1];
    flags_out.z = (result[`F100_WORD_BITS-1:0] == '0);
    flags_out.v = flags_in.v;
    // Signed overflow from the operand and accumulator sign bits
    if (is_add)
      flags_out.v = (accum[`F100_WORD_BITS-1] == operand[`F100_WORD_BITS-1]) &&
                    (result[`F100_WORD_BITS-1] != accum[`F100_WORD_BITS-1]);
    else if (is_sub)
      flags_out.v = (accum[`F100_WORD_BITS-1] != operand[`F100_WORD_BITS-1]) &&
                    (result[`F100_WORD_BITS-1] == accum[`F100_WORD_BITS-1]);
  end

endmodule

`default_nettype wire

//--- hdl/f100_control.sv
//********************************************************************
// F100-L control unit
// Fetch, decode, addressing mode and write-back sequencer around the ALU
//********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_control
(
  input  logic                        raw_clk,
  input  logic                        button_reset,
  input  logic                        button_halt,
  input  logic [`F100_WORD_BITS-1:0]  rdata,
  output f100_pkg::mem_req_t          req,
  output f100_pkg::cpu_status_t       status
);

  import f100_pkg::*;

  cpu_state_e                 state;
  logic [`F100_ADDR_BITS-1:0] pc;
  logic [`F100_ADDR_BITS-1:0] ea;
  logic [`F100_WORD_BITS-1:0] instr;
  logic [`F100_WORD_BITS-1:0] operand;
  logic [`F100_WORD_BITS-1:0] accum;
  logic [`F100_WORD_BITS:0]   result_q;
  dest_e                      dest_q;
  flags_t                     flags;
  logic                       fault;

  logic [`F100_WORD_BITS:0]   alu_result;
  dest_e                      alu_dest;
  flags_t                     alu_flags;

  alu_op_e                    dec_op;
  logic                       dec_halt;
  logic                       dec_known;
  logic                       dec_imm;
  logic [`F100_ADDR_BITS-1:0] dec_ea;

  f100_alu alu_0
  (
    .op        (alu_op_e'(instr[`F100_WORD_BITS-1 -: 4])),
    .accum     (accum),
    .operand   (operand),
    .flags_in  (flags),
    .result    (alu_result),
    .dest      (alu_dest),
    .flags_out (alu_flags)
  );

  // Decode straight from the fetched word
  always_comb
  begin
    dec_op   = alu_op_e'(rdata[`F100_WORD_BITS-1 -: 4]);
    dec_halt = (rdata[15:12] == 4'b0001) && (rdata[11:10] == 2'b01);
    // Zero address field means the operand is the next word
    dec_imm  = (rdata[`F100_ADDR_BITS-1:0] == '0);
    dec_ea   = dec_imm ? pc : rdata[`F100_ADDR_BITS-1:0];
    case (dec_op)
      OP_ADD, OP_ADS, OP_SUB, OP_SBS, OP_CMP,
      OP_AND, OP_NEQ, OP_LDA, OP_STO, OP_JMP: dec_known = 1'b1;
      default: dec_known = 1'b0;
    endcase
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state     <= ST_FETCH_REQ;
      pc        <= `F100_ADDR_BITS'(`F100_RESET_PC);
      accum     <= '0;
      flags     <= '0;
      fault     <= 1'b0;
      req.valid <= 1'b0;
      req.write <= 1'b0;
    end
    else if (!button_halt)
    begin
      state     <= ST_HALTED;
      req.valid <= 1'b0;
    end
    else
    begin
      // A request stays on the bus for one cycle
      req.valid <= 1'b0;
      case (state)
        ST_FETCH_REQ:
        begin
          req.valid <= 1'b1;
          req.write <= 1'b0;
          req.addr  <= pc;
          pc        <= pc + 1'b1;
          state     <= ST_FETCH_CAP;
        end
        ST_FETCH_CAP:
          state <= ST_DECODE;
        ST_DECODE:
        begin
          instr <= rdata;
          if (dec_halt)
            state <= ST_HALTED;
          else if (!dec_known)
          begin
            fault <= 1'b1;
            state <= ST_HALTED;
          end
          else
          begin
            ea        <= dec_ea;
            if (dec_imm)
              pc <= pc + 1'b1;
            req.valid <= 1'b1;
            req.write <= 1'b0;
            req.addr  <= dec_ea;
            state     <= ST_DATA_REQ;
          end
        end
        ST_DATA_REQ:
          state <= ST_DATA_CAP;
        ST_DATA_CAP:
        begin
          operand <= rdata;
          state   <= ST_EXECUTE;
        end
        ST_EXECUTE:
        begin
          result_q <= alu_result;
          dest_q   <= alu_dest;
          flags    <= alu_flags;
          state    <= ST_WRITE_BACK;
        end
        ST_WRITE_BACK:
        begin
          state <= ST_FETCH_REQ;
          case (dest_q)
            DEST_A:  accum <= result_q[`F100_WORD_BITS-1:0];
            DEST_PC: pc    <= result_q[`F100_ADDR_BITS-1:0];
            DEST_MEM:
            begin
              req.valid <= 1'b1;
              req.write <= 1'b1;
              req.addr  <= ea;
              req.data  <= result_q[`F100_WORD_BITS-1:0];
              state     <= ST_WRITE_REL;
            end
            default: state <= ST_FETCH_REQ;
          endcase
        end
        ST_WRITE_REL:
          state <= ST_FETCH_REQ;
        ST_HALTED:
          state <= ST_HALTED;
        default:
        begin
          fault <= 1'b1;
          state <= ST_HALTED;
        end
      endcase
    end
  end

  always_comb
  begin
    status.halted = (state == ST_HALTED);
    status.fault  = fault;
    status.pc     = pc;
    status.accum  = accum;
    status.flags  = flags;
  end

endmodule

`default_nettype wire

//--- hdl/f100_memory.sv
//********************************************************************
// F100-L word memory
// Single-port synchronous RAM, host load port takes the write port first
//********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_memory
(
  input  logic                        raw_clk,
  input  f100_pkg::mem_req_t          req,
  input  f100_pkg::load_t             load,
  output logic [`F100_WORD_BITS-1:0]  rdata
);

  import f100_pkg::*;

  logic [`F100_WORD_BITS-1:0] mem [`F100_MEM_WORDS];
  logic                       wr_en;
  logic [`F100_ADDR_BITS-1:0] wr_addr;
  logic [`F100_WORD_BITS-1:0] wr_data;

  // Host load wins over a core write
  always_comb
  begin
    wr_en   = load.en || (req.valid && req.write);
    wr_addr = load.en ? load.addr : req.addr;
    wr_data = load.en ? load.data : req.data;
  end

  always_ff @(posedge raw_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    if (req.valid && !req.write)
      rdata <= mem[req.addr];
  end

endmodule

`default_nettype wire

//--- hdl/f100_pkg.sv
//********************************************************************
// F100-L core types
// Opcode and sequencer enums, bus, host load, flag and status structs
//********************************************************************

`default_nettype none

`include "f100_settings.svh"

package f100_pkg;

  // Top nibble of a memory-reference instruction
  typedef enum logic [3:0] {
    OP_STO = 4'h4,
    OP_ADS = 4'h5,
    OP_SBS = 4'h6,
    OP_LDA = 4'h8,
    OP_ADD = 4'h9,
    OP_SUB = 4'ha,
    OP_CMP = 4'hb,
    OP_AND = 4'hc,
    OP_NEQ = 4'hd,
    OP_JMP = 4'hf
  } alu_op_e;

  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_A,
    DEST_PC,
    DEST_MEM
  } dest_e;

  typedef enum logic [3:0] {
    ST_FETCH_REQ,
    ST_FETCH_CAP,
    ST_DECODE,
    ST_DATA_REQ,
    ST_DATA_CAP,
    ST_EXECUTE,
    ST_WRITE_BACK,
    ST_WRITE_REL,
    ST_HALTED
  } cpu_state_e;

  // One bus cycle, read data follows a cycle later
  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [`F100_ADDR_BITS-1:0] addr;
    logic [`F100_WORD_BITS-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic                       en;
    logic [`F100_ADDR_BITS-1:0] addr;
    logic [`F100_WORD_BITS-1:0] data;
  } load_t;

  typedef struct packed {
    logic c;
    logic s;
    logic v;
    logic z;
  } flags_t;

  typedef struct packed {
    logic                       halted;
    logic                       fault;
    logic [`F100_ADDR_BITS-1:0] pc;
    logic [`F100_WORD_BITS-1:0] accum;
    flags_t                     flags;
  } cpu_status_t;

endpackage

`default_nettype wire

//--- hdl/f100_settings.svh
//********************************************************************
// F100-L core settings
// Word and address widths, memory depth and the first fetch address
//********************************************************************

`ifndef F100_SETTINGS_SVH
`define F100_SETTINGS_SVH

// Data and instruction width
`define F100_WORD_BITS 16
// Addresses wrap modulo the memory depth
`define F100_ADDR_BITS 11
`define F100_MEM_WORDS 2048

// First fetch address after reset
`define F100_RESET_PC 0

`endif

//--- hdl/f100_top.sv
//********************************************************************
// F100-L core top level
// Control unit and word memory, bus and status brought out
//********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_top
(
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic                   button_halt,
  input  f100_pkg::load_t        load,
  output f100_pkg::mem_req_t     bus_monitor,
  output f100_pkg::cpu_status_t  status
);

  import f100_pkg::*;

  logic [`F100_WORD_BITS-1:0] rdata;

  // The core bus doubles as the observation port
  f100_control control_0
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .rdata        (rdata),
    .req          (bus_monitor),
    .status       (status)
  );

  f100_memory memory_0
  (
    .raw_clk (raw_clk),
    .req     (bus_monitor),
    .load    (load),
    .rdata   (rdata)
  );

endmodule

`default_nettype wire

//--- verification/f100_asserts.sv
//**********************************************************************
// F100-L control assertions
// Bus strobe width, sticky halt and bus state after reset
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

module f100_asserts
(
  input logic                  raw_clk,
  input logic                  button_reset,
  input f100_pkg::mem_req_t    req,
  input f100_pkg::cpu_status_t status
);

  // Request strobe is one cycle wide
  single_cycle_valid: assert property (@(posedge raw_clk) disable iff (!button_reset)
    req.valid |=> !req.valid)
    else $error("bus valid high for two consecutive cycles");

  // Only reset leaves the halted state
  halt_is_sticky: assert property (@(posedge raw_clk) disable iff (!button_reset)
    status.halted |=> status.halted)
    else $error("halted dropped without a reset");

  idle_after_reset: assert property (@(posedge raw_clk)
    !button_reset |=> !req.valid)
    else $error("bus valid in the cycle after reset");

endmodule

bind f100_control f100_asserts control_checks
(
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .req          (req),
  .status       (status)
);

`default_nettype wire

//--- verification/f100_checker.sv
//**********************************************************************
// F100-L core checker
// Reference instruction-set model, compares bus writes in order and
// the final status against the model when the core halts
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_checker
(
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  logic                  button_halt,
  input  f100_pkg::load_t       load,
  input  f100_pkg::mem_req_t    bus_monitor,
  input  f100_pkg::cpu_status_t status,
  output int unsigned           value_errors,
  output int unsigned           other_errors
);

  import f100_pkg::*;

  localparam int MODEL_STEPS = 4096;

  logic [`F100_WORD_BITS-1:0] image [`F100_MEM_WORDS];
  mem_req_t                   exp_writes [$];
  cpu_status_t                exp_status;
  bit                         in_reset     = 1'b0;
  bit                         active       = 1'b0;
  bit                         halt_pressed = 1'b0;
  int unsigned                value_count  = 0;
  int unsigned                other_count  = 0;

  assign value_errors = value_count;
  assign other_errors = other_count;

  // Runs the loaded image to a halt, collecting every memory write
  function automatic cpu_status_t run_model(output mem_req_t writes [$]);
    logic [15:0]                m [`F100_MEM_WORDS];
    cpu_status_t                st;
    logic [15:0]                ir;
    logic [15:0]                opd;
    logic [16:0]                r;
    logic [`F100_ADDR_BITS-1:0] ea;
    alu_op_e                    op;
    mem_req_t                   w;
    int                         step;
    int                         sv;
    m = image;
    st = '0;
    st.pc = `F100_ADDR_BITS'(`F100_RESET_PC);
    for (step = 0; step < MODEL_STEPS && !st.halted; step++)
    begin
      ir = m[st.pc];
      op = alu_op_e'(ir[15:12]);
      st.pc = st.pc + 11'd1;
      if (ir[15:10] == 6'b000101)
        st.halted = 1'b1;
      else if (!(op inside {OP_ADD, OP_ADS, OP_SUB, OP_SBS, OP_CMP,
                            OP_AND, OP_NEQ, OP_LDA, OP_STO, OP_JMP}))
      begin
        st.fault  = 1'b1;
        st.halted = 1'b1;
      end
      else
      begin
        ea = ir[10:0];
        // Zero address field takes the next word as the operand
        if (ea == '0)
        begin
          ea = st.pc;
          st.pc = st.pc + 11'd1;
        end
        opd = m[ea];
        case (op)
          OP_ADD, OP_ADS:         r = {1'b0, opd} + {1'b0, st.accum};
          OP_SUB, OP_SBS, OP_CMP: r = {1'b0, opd} - {1'b0, st.accum};
          OP_AND:                 r = {1'b0, opd & st.accum};
          OP_NEQ:                 r = {1'b0, opd ^ st.accum};
          OP_STO:                 r = {1'b0, st.accum};
          default:                r = {1'b0, opd};
        endcase
        // Overflow when the signed result leaves the 16-bit range
        if (op == OP_ADD || op == OP_ADS)
        begin
          sv = $signed(opd) + $signed(st.accum);
          st.flags.v = (sv > 32767) || (sv < -32768);
        end
        else if (op == OP_SUB || op == OP_SBS)
        begin
          sv = $signed(opd) - $signed(st.accum);
          st.flags.v = (sv > 32767) || (sv < -32768);
        end
        st.flags.c = r[16];
        st.flags.s = r[15];
        st.flags.z = (r[15:0] == 16'h0000);
        if (op inside {OP_STO, OP_ADS, OP_SBS})
        begin
          m[ea] = r[15:0];
          w.valid = 1'b1;
          w.write = 1'b1;
          w.addr  = ea;
          w.data  = r[15:0];
          writes.push_back(w);
        end
        else if (op == OP_JMP)
          st.pc = r[10:0];
        else if (op != OP_CMP)
          st.accum = r[15:0];
      end
    end
    return st;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want)
    begin
      value_count++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  task automatic compare_write;
    mem_req_t want;
    if (!active || halt_pressed)
    begin
      other_count++;
      $display("Bus write to %0h at %0t ns after the core was stopped",
               bus_monitor.addr, $time);
    end
    else if (exp_writes.size() == 0)
    begin
      other_count++;
      $display("Unexpected bus write to %0h at %0t ns", bus_monitor.addr, $time);
    end
    else
    begin
      want = exp_writes.pop_front();
      check_value("bus_monitor.addr", bus_monitor.addr, want.addr);
      check_value("bus_monitor.data", bus_monitor.data, want.data);
    end
  endtask

  task automatic finish_run;
    active = 1'b0;
    if (halt_pressed)
      check_value("status.fault", status.fault, 0);
    else if (!exp_status.halted)
    begin
      other_count++;
      $display("Reference model did not reach a halt within %0d steps", MODEL_STEPS);
    end
    else
    begin
      check_value("status.fault", status.fault, exp_status.fault);
      check_value("status.pc", status.pc, exp_status.pc);
      check_value("status.accum", status.accum, exp_status.accum);
      check_value("status.flags", status.flags, exp_status.flags);
      if (exp_writes.size() != 0)
      begin
        other_count++;
        $display("%0d expected bus writes never appeared before halt at %0t ns",
                 exp_writes.size(), $time);
      end
    end
  endtask

  always @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      if (in_reset && bus_monitor.valid)
      begin
        other_count++;
        $display("Bus cycle valid during reset at %0t ns", $time);
      end
      if (load.en)
        image[load.addr] = load.data;
      in_reset = 1'b1;
      active   = 1'b0;
    end
    else if (in_reset)
    begin
      // First edge out of reset, status still shows the reset values
      in_reset = 1'b0;
      check_value("status.pc", status.pc, `F100_RESET_PC);
      check_value("status.accum", status.accum, 0);
      check_value("status.flags", status.flags, 0);
      check_value("status.halted", status.halted, 0);
      check_value("status.fault", status.fault, 0);
      exp_status   = run_model(exp_writes);
      active       = 1'b1;
      halt_pressed = 1'b0;
    end
    else
    begin
      if (bus_monitor.valid && bus_monitor.write)
        compare_write();
      if (active && status.halted)
        finish_run();
      else if (active && halt_pressed)
      begin
        // The halt button stops the core at the edge that samples it
        other_count++;
        active = 1'b0;
        $display("Core still running a cycle after the halt button at %0t ns", $time);
      end
      if (active && !button_halt)
        halt_pressed = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verification/f100_tb.sv
//**********************************************************************
// F100-L core testbench
// Builds random programs, loads them through the host port and runs
// each one to a halt, with a fault run and a halt button run
//**********************************************************************

`timescale 1ns/1ns
`default_nettype none

`include "f100_settings.svh"

module f100_tb;

  import f100_pkg::*;

  localparam int          RUNS         = 6;
  localparam int          FAULT_RUN    = 4;
  localparam int          HALT_RUN     = 5;
  localparam int          PROG_INSTRS  = 16;
  localparam int          HALT_TIMEOUT = 2000;
  localparam logic [15:0] HALT_WORD    = 16'h1400;

  logic                       raw_clk;
  logic                       button_reset;
  logic                       button_halt;
  load_t                      load;
  mem_req_t                   bus_monitor;
  cpu_status_t                status;
  logic [`F100_WORD_BITS-1:0] image [`F100_MEM_WORDS];
  int unsigned                value_errors;
  int unsigned                other_errors;
  int unsigned                timeout_errors;

  f100_top uut
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .load         (load),
    .bus_monitor  (bus_monitor),
    .status       (status)
  );

  f100_checker checks
  (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .load         (load),
    .bus_monitor  (bus_monitor),
    .status       (status),
    .value_errors (value_errors),
    .other_errors (other_errors)
  );

  initial
    raw_clk = 1'b0;

  always
    #50 raw_clk = ~raw_clk;

  // Index 0..9 onto the kept memory-reference opcodes
  function automatic alu_op_e pick_op(input int unsigned idx);
    case (idx)
      0: return OP_LDA;
      1: return OP_ADD;
      2: return OP_SUB;
      3: return OP_AND;
      4: return OP_NEQ;
      5: return OP_CMP;
      6: return OP_STO;
      7: return OP_ADS;
      8: return OP_SBS;
      default: return OP_JMP;
    endcase
  endfunction

  task automatic build_program(input int run);
    int          addr;
    int          n;
    alu_op_e     op;
    logic [15:0] salt;
    salt = 16'($urandom);
    // Fill pattern mixes every address bit
    for (addr = 0; addr < `F100_MEM_WORDS; addr++)
      image[addr] = 16'(addr * 40503) ^ salt;
    addr = 0;
    for (n = 0; n < PROG_INSTRS; n++)
    begin
      op = pick_op($urandom % 10);
      if (op == OP_JMP)
      begin
        // Jump over a direct store that must never reach the bus
        image[addr]     = {OP_JMP, 12'h000};
        image[addr + 1] = 16'(addr + 3);
        image[addr + 2] = {OP_STO, 2'b01, 10'($urandom)};
        addr += 3;
      end
      else if ($urandom % 2 == 1)
      begin
        image[addr]     = {op, 12'h000};
        image[addr + 1] = 16'($urandom);
        addr += 2;
      end
      else
      begin
        // Direct operands live in the upper half, clear of the code
        image[addr] = {op, 2'b01, 10'($urandom)};
        addr += 1;
      end
    end
    if (run == FAULT_RUN)
      image[addr] = {(($urandom % 2 == 1) ? 4'h7 : 4'he), 12'($urandom)};
    else
      image[addr] = HALT_WORD;
  endtask

  task automatic load_image;
    int addr;
    for (addr = 0; addr < `F100_MEM_WORDS; addr++)
    begin
      @(negedge raw_clk);
      load.en   = 1'b1;
      load.addr = addr[`F100_ADDR_BITS-1:0];
      load.data = image[addr];
    end
    @(negedge raw_clk);
    load = '0;
  endtask

  task automatic wait_for_halt(output bit done);
    int cycles;
    done = 1'b0;
    for (cycles = 0; cycles < HALT_TIMEOUT && !done; cycles++)
    begin
      @(negedge raw_clk);
      done = status.halted;
    end
  endtask

  initial
  begin
    int run;
    bit halted_ok;
    bit stop;
    button_reset   = 1'b0;
    button_halt    = 1'b1;
    load           = '0;
    timeout_errors = 0;
    stop           = 1'b0;
    void'($urandom(15873));
    for (run = 0; run < RUNS && !stop; run++)
    begin
      @(negedge raw_clk);
      button_reset = 1'b0;
      button_halt  = 1'b1;
      repeat (4) @(negedge raw_clk);
      // Memory is filled while the core is still held in reset
      build_program(run);
      load_image();
      button_reset = 1'b1;
      if (run == HALT_RUN)
      begin
        repeat (30) @(negedge raw_clk);
        button_halt = 1'b0;
      end
      wait_for_halt(halted_ok);
      if (!halted_ok)
      begin
        $display("Timeout: run %0d did not halt within %0d cycles", run, HALT_TIMEOUT);
        timeout_errors++;
        stop = 1'b1;
      end
      // Let the checker see the halted cycle before the next reset
      repeat (2) @(negedge raw_clk);
    end
    $display("Errors: %0d value mismatches, %0d other checker errors, %0d timeouts",
             value_errors, other_errors, timeout_errors);
    if (value_errors + other_errors + timeout_errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
